// File: hw/bus_pkg.sv
// cpu bus map is fixed; only full 32-bit address matches are decoded, byte enables are not used
`default_nettype none

package bus_pkg;

    localparam int BUS_W   = 32;
    localparam int COUNT_W = 6;

    localparam logic [BUS_W-1:0] ADDR_PATH_WORD = 32'h0200_0008;
    localparam logic [BUS_W-1:0] ADDR_START     = 32'h0200_000c;
    localparam logic [BUS_W-1:0] START_CODE     = 32'h0000_0001;

    // what one sampled bus write means to the sampler
    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_PATH_WORD = 2'd1,
        CMD_START     = 2'd2
    } cmd_t;

endpackage

`default_nettype wire

// File: hw/nav_pkg.sv
// node numbers are 5 bits; the turn list covers only the junctions of this map, anything else is forward
`default_nettype none

package nav_pkg;

    localparam int NODE_W     = 5;
    localparam int PATH_DEPTH = 16;
    localparam int IDX_W      = 4;
    localparam int TURN_COUNT = 14;

    typedef logic [NODE_W-1:0] node_t;

    typedef enum logic [2:0] {
        HEAD_STOP    = 3'd0,
        HEAD_FORWARD = 3'd1,
        HEAD_LEFT    = 3'd2,
        HEAD_RIGHT   = 3'd3,
        HEAD_REVERSE = 3'd4
    } heading_t;

    typedef struct packed {
        node_t    present;
        node_t    past;
        node_t    future;
        heading_t head;
    } turn_t;

    // present, past, future, manoeuvre
    localparam turn_t TURN_TABLE [TURN_COUNT] = '{
        '{5'd26, 5'd28, 5'd27, HEAD_LEFT},
        '{5'd26, 5'd25, 5'd27, HEAD_RIGHT},
        '{5'd19, 5'd18, 5'd20, HEAD_LEFT},
        '{5'd19, 5'd12, 5'd20, HEAD_RIGHT},
        '{5'd19, 5'd20, 5'd12, HEAD_RIGHT},
        '{5'd16, 5'd18, 5'd17, HEAD_LEFT},
        '{5'd16, 5'd14, 5'd17, HEAD_RIGHT},
        '{5'd14, 5'd16, 5'd15, HEAD_LEFT},
        '{5'd14, 5'd13, 5'd15, HEAD_RIGHT},
        '{5'd12, 5'd8,  5'd13, HEAD_LEFT},
        '{5'd12, 5'd13, 5'd8,  HEAD_RIGHT},
        '{5'd12, 5'd8,  5'd19, HEAD_RIGHT},
        '{5'd4,  5'd6,  5'd5,  HEAD_LEFT},
        '{5'd4,  5'd3,  5'd5,  HEAD_RIGHT}
    };

endpackage

`default_nettype wire

// File: hw/path_load_if.sv
// plain strobes only, no handshake; a strobe is consumed in the cycle it is high
`default_nettype none

interface path_load_if;
    logic                      wr_en;   // one-cycle path write
    logic [nav_pkg::IDX_W-1:0] wr_idx;
    nav_pkg::node_t            wr_node;
    logic                      start;   // one-cycle start command

    modport decoder (output wr_en, output wr_idx, output wr_node, output start);
    modport memory  (input wr_en, input wr_idx, input wr_node);
    modport tracker (input start);
endinterface

interface node_window_if;
    nav_pkg::node_t past;
    nav_pkg::node_t present;
    nav_pkg::node_t future;
    logic           step;   // high the cycle after a window shift

    modport tracker (output past, output present, output future, output step);
    modport decoder (input past, input present, input future, input step);
endinterface

`default_nettype wire

// File: hw/cpu_write_decoder.sv
// writes beyond sixteen path words are dropped until the next start; the start count wraps
`default_nettype none

module cpu_write_decoder (
    input  wire                         i_node_update,
    input  wire                         i_jreset,
    input  wire                         i_mem_write,
    input  wire  [bus_pkg::BUS_W-1:0]   i_data_adr,
    input  wire  [bus_pkg::BUS_W-1:0]   i_write_data,
    output logic                        o_cpu_done,
    output logic [bus_pkg::COUNT_W-1:0] o_start_count,
    path_load_if.decoder                load
);

    bus_pkg::cmd_t             cmd;
    logic [nav_pkg::IDX_W:0]   wr_ptr;   // one extra bit flags a full path
    logic                      ptr_full;

    always_comb begin
        cmd = bus_pkg::CMD_NONE;
        if (i_mem_write) begin
            if (i_data_adr == bus_pkg::ADDR_PATH_WORD) begin
                cmd = bus_pkg::CMD_PATH_WORD;
            end else if (i_data_adr == bus_pkg::ADDR_START &&
                         i_write_data == bus_pkg::START_CODE) begin
                cmd = bus_pkg::CMD_START;
            end
        end
    end

    assign ptr_full = wr_ptr[nav_pkg::IDX_W];

    assign load.wr_en   = (cmd == bus_pkg::CMD_PATH_WORD) && !ptr_full;
    assign load.wr_idx  = wr_ptr[nav_pkg::IDX_W-1:0];
    assign load.wr_node = i_write_data[nav_pkg::NODE_W-1:0];   // low bits only
    assign load.start   = (cmd == bus_pkg::CMD_START);

    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            wr_ptr        <= '0;
            o_cpu_done    <= 1'b0;
            o_start_count <= '0;
        end else if (load.start) begin
            wr_ptr        <= '0;
            o_cpu_done    <= 1'b1;   // sticky
            o_start_count <= o_start_count + 1'b1;
        end else if (load.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/path_memory.sv
// read is combinational, so a word written on one edge is visible from the next cycle on
`default_nettype none

module path_memory (
    input  wire                         i_node_update,
    input  wire                         i_jreset,
    path_load_if.memory                 load,
    input  wire  [nav_pkg::IDX_W-1:0]   i_rd_idx,
    output nav_pkg::node_t              o_rd_node
);

    nav_pkg::node_t path_q [nav_pkg::PATH_DEPTH];

    // entries clear to node 0 so an unloaded path reads back as zeros
    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            for (int i = 0; i < nav_pkg::PATH_DEPTH; i++) begin
                path_q[i] <= '0;
            end
        end else if (load.wr_en) begin
            path_q[load.wr_idx] <= load.wr_node;
        end
    end

    assign o_rd_node = path_q[i_rd_idx];

endmodule

`default_nettype wire

// File: hw/node_tracker.sv
// start rewinds the read index but keeps the window; start beats a node strobe on the same edge
`default_nettype none

module node_tracker (
    input  wire                         i_node_update,
    input  wire                         i_jreset,
    input  wire                         i_node_reached,
    path_load_if.tracker                load,
    input  wire  nav_pkg::node_t        i_rd_node,
    output logic [nav_pkg::IDX_W-1:0]   o_rd_idx,
    node_window_if.tracker              win
);

    logic do_step;

    assign do_step = i_node_reached && !load.start;

    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            o_rd_idx <= nav_pkg::IDX_W'(1);   // entry 0 is already the first future
        end else if (load.start) begin
            o_rd_idx <= nav_pkg::IDX_W'(1);
        end else if (do_step) begin
            o_rd_idx <= o_rd_idx + 1'b1;   // wraps at 16
        end
    end

    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            win.past    <= nav_pkg::node_t'(0);
            win.present <= nav_pkg::node_t'(0);
            win.future  <= nav_pkg::node_t'(1);
        end else if (do_step) begin
            win.past    <= win.present;
            win.present <= win.future;
            win.future  <= i_rd_node;
        end
    end

    // tells the decoder the window just moved
    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            win.step <= 1'b0;
        end else begin
            win.step <= do_step;
        end
    end

endmodule

`default_nettype wire

// File: hw/turn_decoder.sv
// headings update only on the step pulse, two edges after the node strobe; unlisted windows give forward
`default_nettype none

module turn_decoder (
    input  wire                 i_node_update,
    input  wire                 i_jreset,
    node_window_if.decoder      win,
    output nav_pkg::heading_t   o_heading,
    output nav_pkg::heading_t   o_prev_heading
);

    nav_pkg::heading_t decoded;

    always_comb begin
        decoded = nav_pkg::HEAD_FORWARD;
        if (win.past == win.future) begin
            decoded = nav_pkg::HEAD_REVERSE;   // dead end, turn back
        end else begin
            for (int i = 0; i < nav_pkg::TURN_COUNT; i++) begin
                if (win.present == nav_pkg::TURN_TABLE[i].present &&
                    win.past    == nav_pkg::TURN_TABLE[i].past &&
                    win.future  == nav_pkg::TURN_TABLE[i].future) begin
                    decoded = nav_pkg::TURN_TABLE[i].head;
                end
            end
        end
    end

    always_ff @(posedge i_node_update or posedge i_jreset) begin
        if (i_jreset) begin
            o_heading      <= nav_pkg::HEAD_STOP;
            o_prev_heading <= nav_pkg::HEAD_STOP;
        end else if (win.step) begin
            o_prev_heading <= o_heading;
            o_heading      <= decoded;
        end
    end

endmodule

`default_nettype wire

// File: hw/path_sampler.sv
// single clock node_update; node arrival is a one-cycle strobe, at most one step per cycle
`default_nettype none

module path_sampler (
    input  wire                         node_update,
    input  wire                         jreset,
    input  wire                         i_mem_write,
    input  wire  [bus_pkg::BUS_W-1:0]   i_data_adr,
    input  wire  [bus_pkg::BUS_W-1:0]   i_write_data,
    input  wire                         i_node_reached,
    output logic                        o_cpu_done,
    output logic [bus_pkg::COUNT_W-1:0] o_start_count,
    output nav_pkg::node_t              o_past_node,
    output nav_pkg::node_t              o_present_node,
    output nav_pkg::node_t              o_future_node,
    output logic                        o_forward_en,
    output logic                        o_left_en,
    output logic                        o_right_en,
    output logic                        o_reverse_en,
    output logic                        o_prev_forward_en,
    output logic                        o_prev_left_en,
    output logic                        o_prev_right_en,
    output logic                        o_prev_reverse_en
);

    path_load_if   load ();
    node_window_if win ();

    logic [nav_pkg::IDX_W-1:0] rd_idx;
    nav_pkg::node_t            rd_node;
    nav_pkg::heading_t         heading;
    nav_pkg::heading_t         prev_heading;

    cpu_write_decoder cpu_write_decoder_inst (
        .i_node_update (node_update),
        .i_jreset      (jreset),
        .i_mem_write   (i_mem_write),
        .i_data_adr    (i_data_adr),
        .i_write_data  (i_write_data),
        .o_cpu_done    (o_cpu_done),
        .o_start_count (o_start_count),
        .load          (load)
    );

    path_memory path_memory_inst (
        .i_node_update (node_update),
        .i_jreset      (jreset),
        .load          (load),
        .i_rd_idx      (rd_idx),
        .o_rd_node     (rd_node)
    );

    node_tracker node_tracker_inst (
        .i_node_update  (node_update),
        .i_jreset       (jreset),
        .i_node_reached (i_node_reached),
        .load           (load),
        .i_rd_node      (rd_node),
        .o_rd_idx       (rd_idx),
        .win            (win)
    );

    turn_decoder turn_decoder_inst (
        .i_node_update  (node_update),
        .i_jreset       (jreset),
        .win            (win),
        .o_heading      (heading),
        .o_prev_heading (prev_heading)
    );

    assign o_past_node    = win.past;
    assign o_present_node = win.present;
    assign o_future_node  = win.future;

    // one-hot enables, all low while stopped
    assign o_forward_en      = (heading == nav_pkg::HEAD_FORWARD);
    assign o_left_en         = (heading == nav_pkg::HEAD_LEFT);
    assign o_right_en        = (heading == nav_pkg::HEAD_RIGHT);
    assign o_reverse_en      = (heading == nav_pkg::HEAD_REVERSE);
    assign o_prev_forward_en = (prev_heading == nav_pkg::HEAD_FORWARD);
    assign o_prev_left_en    = (prev_heading == nav_pkg::HEAD_LEFT);
    assign o_prev_right_en   = (prev_heading == nav_pkg::HEAD_RIGHT);
    assign o_prev_reverse_en = (prev_heading == nav_pkg::HEAD_REVERSE);

endmodule

`default_nettype wire

// File: tb/path_sampler_properties.sv
// checked on rising node_update edges outside reset; a start write on a strobe edge skips the step check
`default_nettype none

module path_sampler_properties (
    input wire                      i_node_update,
    input wire                      i_jreset,
    input wire                      i_mem_write,
    input wire [bus_pkg::BUS_W-1:0] i_data_adr,
    input wire [bus_pkg::BUS_W-1:0] i_write_data,
    input wire                      i_node_reached,
    input wire                      i_cpu_done,
    input wire nav_pkg::node_t      i_past_node,
    input wire nav_pkg::node_t      i_present_node,
    input wire [3:0]                i_enables,
    input wire [3:0]                i_prev_enables
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    logic start_cmd;

    assign start_cmd = i_mem_write && i_data_adr == bus_pkg::ADDR_START &&
                       i_write_data == bus_pkg::START_CODE;   // start beats the strobe

    // once a manoeuvre is set the enables never drop back to all zero
    a_enables_onehot: assert property (@(posedge i_node_update) disable iff (i_jreset)
        $onehot0(i_enables) && $onehot0(i_prev_enables) &&
        ($past(i_enables) == 4'b0000 || $onehot(i_enables)) &&
        ($past(i_prev_enables) == 4'b0000 || $onehot(i_prev_enables)))
        else begin
            failures++;
            $error("manoeuvre enables are not one-hot or fell back to all zero");
        end

    a_done_sticky: assert property (@(posedge i_node_update) disable iff (i_jreset)
        $past(i_cpu_done) |-> i_cpu_done)
        else begin
            failures++;
            $error("cpu done fell outside reset");
        end

    a_past_follows: assert property (@(posedge i_node_update) disable iff (i_jreset)
        i_node_reached && !start_cmd |=> i_past_node == $past(i_present_node))
        else begin
            failures++;
            $error("past node did not take the earlier present node");
        end

endmodule

bind path_sampler path_sampler_properties path_sampler_properties_inst (
    .i_node_update  (node_update),
    .i_jreset       (jreset),
    .i_mem_write    (i_mem_write),
    .i_data_adr     (i_data_adr),
    .i_write_data   (i_write_data),
    .i_node_reached (i_node_reached),
    .i_cpu_done     (o_cpu_done),
    .i_past_node    (o_past_node),
    .i_present_node (o_present_node),
    .i_enables      ({o_forward_en, o_left_en, o_right_en, o_reverse_en}),
    .i_prev_enables ({o_prev_forward_en, o_prev_left_en, o_prev_right_en, o_prev_reverse_en})
);

`default_nettype wire

// File: tb/path_sampler_tb.sv
// one start at a time and inputs change on falling edges only; random paths use nodes 1 to 29
`default_nettype none

module path_sampler_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    localparam int RAND_PATHS   = 10;
    localparam int RAND_STEPS   = 24;
    // four times what the directed and random tests need
    localparam int TIMEOUT_CYCLES =
        4 * (2 * RESET_CYCLES + 150 + RAND_PATHS * (nav_pkg::PATH_DEPTH + 1 + 2 * RAND_STEPS));
    localparam int H_STOP  = 0;
    localparam int H_FWD   = 1;
    localparam int H_LEFT  = 2;
    localparam int H_RIGHT = 3;
    localparam int H_REV   = 4;

    logic                        node_update;
    logic                        jreset;
    logic                        i_mem_write;
    logic [bus_pkg::BUS_W-1:0]   i_data_adr;
    logic [bus_pkg::BUS_W-1:0]   i_write_data;
    logic                        i_node_reached;
    logic                        o_cpu_done;
    logic [bus_pkg::COUNT_W-1:0] o_start_count;
    nav_pkg::node_t              o_past_node, o_present_node, o_future_node;
    logic                        o_forward_en, o_left_en, o_right_en, o_reverse_en;
    logic                        o_prev_forward_en, o_prev_left_en;
    logic                        o_prev_right_en, o_prev_reverse_en;
    logic [3:0]                  dut_en, dut_prev_en;

    nav_pkg::node_t              m_mem [nav_pkg::PATH_DEPTH];   // expected path store
    nav_pkg::node_t              m_past, m_present, m_future;
    logic [nav_pkg::IDX_W-1:0]   m_idx;
    int                          m_ptr;
    logic                        m_done;
    logic [bus_pkg::COUNT_W-1:0] m_count;
    int                          m_head, m_prev;

    nav_pkg::node_t path_q [$];
    logic [31:0]    rng = 32'd38;
    string          test_name;
    int             checks, errors, test_errors, cycles, asserts;

    path_sampler path_sampler_inst (.*);

    assign dut_en      = {o_forward_en, o_left_en, o_right_en, o_reverse_en};
    assign dut_prev_en = {o_prev_forward_en, o_prev_left_en, o_prev_right_en, o_prev_reverse_en};

    initial begin
        node_update = 1'b0;
        forever #5 node_update = ~node_update;
    end

    always @(posedge node_update) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // dead end first, then the junction list of the map, else straight on
    function automatic int expected_heading(input nav_pkg::node_t past, present, future);
        if (past == future) begin
            return H_REV;
        end
        case ({present, past, future})
            {5'd26, 5'd28, 5'd27}, {5'd19, 5'd18, 5'd20}, {5'd16, 5'd18, 5'd17},
            {5'd14, 5'd16, 5'd15}, {5'd12, 5'd8, 5'd13}, {5'd4, 5'd6, 5'd5}:
                return H_LEFT;
            {5'd26, 5'd25, 5'd27}, {5'd19, 5'd12, 5'd20}, {5'd19, 5'd20, 5'd12},
            {5'd16, 5'd14, 5'd17}, {5'd14, 5'd13, 5'd15}, {5'd12, 5'd13, 5'd8},
            {5'd12, 5'd8, 5'd19}, {5'd4, 5'd3, 5'd5}:
                return H_RIGHT;
            default:
                return H_FWD;
        endcase
    endfunction

    function automatic logic [3:0] heading_bits(input int head);
        case (head)
            H_FWD:   return 4'b1000;
            H_LEFT:  return 4'b0100;
            H_RIGHT: return 4'b0010;
            H_REV:   return 4'b0001;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic void clear_model();
        foreach (m_mem[i]) begin
            m_mem[i] = '0;
        end
        m_past    = '0;
        m_present = '0;
        m_future  = nav_pkg::node_t'(1);
        m_idx     = nav_pkg::IDX_W'(1);
        m_ptr     = 0;
        m_done    = 1'b0;
        m_count   = '0;
        m_head    = H_STOP;
        m_prev    = H_STOP;
    endfunction

    function automatic void store_word(input nav_pkg::node_t node);
        if (m_ptr < nav_pkg::PATH_DEPTH) begin   // later words are lost
            m_mem[m_ptr[nav_pkg::IDX_W-1:0]] = node;
            m_ptr++;
        end
    endfunction

    function automatic void rewind_path();
        m_ptr   = 0;
        m_idx   = nav_pkg::IDX_W'(1);
        m_done  = 1'b1;
        m_count = m_count + 1'b1;
    endfunction

    function automatic void advance_window();
        m_past    = m_present;
        m_present = m_future;
        m_future  = m_mem[m_idx];
        m_idx     = m_idx + 1'b1;
        m_prev    = m_head;
        m_head    = expected_heading(m_past, m_present, m_future);
    endfunction

    task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            test_errors++;
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic verify_window();
        check("past node", 32'(m_past), 32'(o_past_node));
        check("present node", 32'(m_present), 32'(o_present_node));
        check("future node", 32'(m_future), 32'(o_future_node));
    endtask

    task automatic verify_status();
        check("cpu done", 32'(m_done), 32'(o_cpu_done));
        check("start count", 32'(m_count), 32'(o_start_count));
    endtask

    task automatic verify_heads();
        check("enables", 32'(heading_bits(m_head)), 32'(dut_en));
        check("previous enables", 32'(heading_bits(m_prev)), 32'(dut_prev_en));
    endtask

    task automatic report_test();
        $display("test %s finished, %0d errors", test_name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
    endtask

    task automatic apply_reset();
        jreset         = 1'b1;
        i_mem_write    = 1'b0;
        i_data_adr     = '0;
        i_write_data   = '0;
        i_node_reached = 1'b0;
        repeat (RESET_CYCLES) @(negedge node_update);
        jreset = 1'b0;
        clear_model();
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
        i_mem_write  = 1'b1;
        i_data_adr   = adr;
        i_write_data = data;
        @(negedge node_update);   // sampled on the rising edge in between
        i_mem_write  = 1'b0;
        i_data_adr   = '0;
        i_write_data = '0;
    endtask

    task automatic start_path();
        bus_write(bus_pkg::ADDR_START, bus_pkg::START_CODE);
        rewind_path();
        verify_status();
    endtask

    task automatic load_path();
        foreach (path_q[i]) begin
            bus_write(bus_pkg::ADDR_PATH_WORD, 32'(path_q[i]));
            store_word(path_q[i]);
        end
        start_path();
        verify_window();   // start keeps the window
    endtask

    // window moves on the strobe edge, headings one edge later
    task automatic step_node();
        i_node_reached = 1'b1;
        @(negedge node_update);
        i_node_reached = 1'b0;
        advance_window();
        verify_window();
        @(negedge node_update);
        verify_heads();
    endtask

    task automatic reset_values();
        test_name = "reset_values";
        verify_window();
        verify_status();
        verify_heads();
        report_test();
    endtask

    task automatic load_and_step();
        test_name = "load_and_step";
        path_q = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd4, 5'd6, 5'd7, 5'd6};
        load_path();
        repeat (path_q.size()) step_node();
        report_test();
    endtask

    task automatic manoeuvre_sequence();
        int want [9] = '{H_FWD, H_FWD, H_FWD, H_RIGHT, H_REV, H_FWD, H_FWD, H_REV, H_FWD};
        int prev_want;
        test_name = "manoeuvre_sequence";
        apply_reset();
        load_path();
        prev_want = H_STOP;
        for (int i = 0; i < 9; i++) begin
            step_node();
            check("heading", 32'(heading_bits(want[i])), 32'(dut_en));
            check("previous heading", 32'(heading_bits(prev_want)), 32'(dut_prev_en));
            prev_want = want[i];
        end
        report_test();
    endtask

    task automatic ignored_writes();
        test_name = "ignored_writes";
        bus_write(32'h0200_0010, 32'd9);         // unmapped address
        bus_write(bus_pkg::ADDR_START, 32'd2);   // wrong start code
        verify_status();
        verify_window();
        repeat (7) step_node();                  // runs on from 10 and wraps to entry 0
        start_path();
        repeat (2) step_node();                  // entries 1 and 2 again
        for (int i = 0; i < nav_pkg::PATH_DEPTH + 2; i++) begin
            bus_write(bus_pkg::ADDR_PATH_WORD, 32'(i + 10));
            store_word(nav_pkg::node_t'(i + 10));
        end
        start_path();
        repeat (nav_pkg::PATH_DEPTH) step_node();   // full lap, wraps to entry 0
        report_test();
    endtask

    task automatic random_walks();
        test_name = "random_walks";
        for (int p = 0; p < RAND_PATHS; p++) begin
            path_q.delete();
            repeat (nav_pkg::PATH_DEPTH) begin
                rng = xorshift(rng);
                path_q.push_back(nav_pkg::node_t'(rng % 32'd29 + 32'd1));
            end
            load_path();
            repeat (RAND_STEPS) step_node();
        end
        report_test();
    endtask

    initial begin
        apply_reset();
        reset_values();
        load_and_step();
        manoeuvre_sequence();
        ignored_writes();
        random_walks();
        asserts = path_sampler_inst.path_sampler_properties_inst.failures;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/bus_pkg.sv
hw/nav_pkg.sv
hw/path_load_if.sv
hw/cpu_write_decoder.sv
hw/path_memory.sv
hw/node_tracker.sv
hw/turn_decoder.sv
hw/path_sampler.sv
tb/path_sampler_properties.sv
tb/path_sampler_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= path_sampler_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
